// File: obi_mem_sys.f
hdl/obi_pkg.sv
hdl/obi_sys_pkg.sv
hdl/obi_fifo.sv
hdl/obi_rr_arb.sv
hdl/obi_mux.sv
hdl/obi_sram.sv
hdl/obi_mem_sys.sv
sim/obi_mem_sys_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert --timing -Wno-fatal
TOP       := obi_mem_sys_tb
FILELIST  := obi_mem_sys.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/obi_mem_sys_tb.sv
// ####################
// OBI memory subsystem testbench
// Directed tests against a word model and per-manager response queues
// ####################

`timescale 1ns/1ps
`default_nettype none

module obi_mem_sys_tb;

  import obi_pkg::*;
  import obi_sys_pkg::*;

  localparam int unsigned NumMgr      = NumMgrDefault;
  localparam int unsigned MemWords    = MemWordsDefault;
  localparam int unsigned NumMaxTrans = NumMaxTransDefault;
  localparam int unsigned RspDepth    = RspDepthDefault;
  // In flight is capped by the ID FIFO and by the SRAM response buffer
  localparam int unsigned MaxInFlight = (NumMaxTrans < RspDepth) ? NumMaxTrans : RspDepth;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned Burst       = 8;
  localparam int unsigned MaxHold     = 22;
  localparam int unsigned SettleWait  = 2 * NumMgr + 4;
  // Transactions of all tests, in test order
  localparam int unsigned TotalTrans  = 4 + 2 * NumMgr * Burst + 8 + 4 + 2 * NumMgr;
  localparam int unsigned TimeoutCycles =
    TotalTrans * (NumMgr + 4) + MaxHold + SettleWait + ResetCycles;

  logic                  clk_i;
  logic                  rst_n_i;
  obi_req_t [NumMgr-1:0] mgr_req = '0;
  obi_rsp_t [NumMgr-1:0] mgr_rsp;
  // Per-manager rready hold-off
  logic     [NumMgr-1:0] stall;
  int                    seed = 25;

  // Reference model state
  logic [DataWidth-1:0] mem_model [MemWords];
  obi_a_chan_t          a_q       [NumMgr][$];
  obi_r_chan_t          exp_q     [NumMgr][$];
  int unsigned          sent_cnt  [NumMgr] = '{default: 0};
  int unsigned          wait_cnt  [NumMgr] = '{default: 0};
  logic                 held_vld  [NumMgr] = '{default: 1'b0};
  obi_r_chan_t          held_r    [NumMgr];
  int unsigned          gnt_cnt    = 0;
  int unsigned          done_cnt   = 0;
  int unsigned          stall_hits = 0;
  int unsigned          cycle_cnt  = 0;

  obi_mem_sys #(
    .NumMgr      (NumMgr),
    .MemWords    (MemWords),
    .NumMaxTrans (NumMaxTrans),
    .RspDepth    (RspDepth)
  ) i_obi_mem_sys (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .mgr_req_i (mgr_req),
    .mgr_rsp_o (mgr_rsp)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_r(input string what, input obi_r_chan_t got, input obi_r_chan_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %s rdata 0x%h err 0x%h, expected rdata 0x%h err 0x%h",
                          what, got.rdata, got.err, exp.rdata, exp.err));
    end
  endtask

  task automatic check_gnt_count(input string what, input int unsigned got,
                                 input int unsigned lo, input int unsigned hi);
    if (got < lo || got > hi) begin
      abort_run($sformatf("ERROR: %s 0x%h, expected 0x%h to 0x%h", what, got, lo, hi));
    end
  endtask

  // Expected R channel for one granted request, memory updated as a side effect
  function automatic obi_r_chan_t model_access(input obi_a_chan_t a);
    logic [AddrWidth-1:0] word;
    obi_r_chan_t          r;
    r    = '0;
    word = a.addr / BeWidth;
    if (word >= MemWords) begin
      r.err = 1'b1;
    end else if (a.we) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (a.be[b]) begin
          mem_model[word][8*b +: 8] = a.wdata[8*b +: 8];
        end
      end
    end else begin
      r.rdata = mem_model[word];
    end
    return r;
  endfunction

  function automatic obi_a_chan_t make_a(input logic we, input int unsigned word,
                                         input logic [BeWidth-1:0] be,
                                         input logic [DataWidth-1:0] wdata);
    obi_a_chan_t a;
    a.addr  = AddrWidth'(word * BeWidth);
    a.we    = we;
    a.be    = be;
    a.wdata = wdata;
    return a;
  endfunction

  // Private word range of each manager in the burst tests
  function automatic int unsigned burst_base(input int unsigned m);
    return 32 + 16 * m;
  endfunction

  // Present the oldest unsent request of each manager
  always @(posedge clk_i) begin : drive_managers
    #2;
    for (int m = 0; m < NumMgr; m++) begin
      mgr_req[m].rready = !stall[m];
      if (sent_cnt[m] < a_q[m].size()) begin
        mgr_req[m].req = 1'b1;
        mgr_req[m].a   = a_q[m][sent_cnt[m]];
      end else begin
        mgr_req[m].req = 1'b0;
        mgr_req[m].a   = '0;
      end
    end
  end

  // Sampled mid-cycle, handshakes complete at the next rising edge
  always @(negedge clk_i) begin : monitor_bus
    int granted;
    int rvalid_cnt;
    granted    = -1;
    rvalid_cnt = 0;
    if (rst_n_i) begin
      for (int m = 0; m < NumMgr; m++) begin
        // A stalled response has to stay put
        if (held_vld[m]) begin
          if (!mgr_rsp[m].rvalid) begin
            abort_run($sformatf("Manager %0d lost its response while stalled", m));
          end
          check_r($sformatf("mgr%0d stalled r", m), mgr_rsp[m].r, held_r[m]);
        end
        held_vld[m] = mgr_rsp[m].rvalid && !mgr_req[m].rready;
        held_r[m]   = mgr_rsp[m].r;
        if (held_vld[m]) begin
          stall_hits++;
        end
        if (mgr_rsp[m].rvalid) begin
          rvalid_cnt++;
        end
        if (mgr_rsp[m].rvalid && mgr_req[m].rready) begin
          if (exp_q[m].size() == 0) begin
            abort_run($sformatf("Manager %0d got a response it never asked for", m));
          end
          check_r($sformatf("mgr%0d r", m), mgr_rsp[m].r, exp_q[m].pop_front());
          done_cnt++;
        end
        // Model runs in grant order
        if (mgr_req[m].req && mgr_rsp[m].gnt) begin
          exp_q[m].push_back(model_access(mgr_req[m].a));
          sent_cnt[m]++;
          gnt_cnt++;
          granted = m;
        end
      end
      if (rvalid_cnt > 1) begin
        abort_run("Response valid on more than one manager in the same cycle");
      end
      // Fairness, grants passed by each waiting manager
      for (int m = 0; m < NumMgr; m++) begin
        if (!mgr_req[m].req || m == granted) begin
          wait_cnt[m] = 0;
        end else if (granted >= 0) begin
          wait_cnt[m]++;
          check_gnt_count($sformatf("mgr%0d grants passed", m), wait_cnt[m], 0, NumMgr - 1);
        end
      end
      check_gnt_count("outstanding", gnt_cnt - done_cnt, 0, MaxInFlight);
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      abort_run($sformatf("Timeout, tests still running after %0d cycles", cycle_cnt));
    end
  end

  // Returns at a rising edge once every request is answered
  task automatic wait_idle();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk_i);
      busy = 1'b0;
      for (int m = 0; m < NumMgr; m++) begin
        if (sent_cnt[m] != a_q[m].size() || exp_q[m].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  // Full write, read back, then a partial merge
  task automatic test_write_read();
    logic [DataWidth-1:0] d0;
    logic [DataWidth-1:0] d1;
    d0 = $random(seed);
    d1 = $random(seed);
    a_q[0].push_back(make_a(1'b1, 3, '1, d0));
    a_q[0].push_back(make_a(1'b0, 3, '0, '0));
    a_q[0].push_back(make_a(1'b1, 3, 4'b0101, d1));
    a_q[0].push_back(make_a(1'b0, 3, '0, '0));
    wait_idle();
  endtask

  task automatic test_concurrent_bursts();
    logic [DataWidth-1:0] d;
    for (int m = 0; m < NumMgr; m++) begin
      for (int k = 0; k < Burst; k++) begin
        d = $random(seed);
        a_q[m].push_back(make_a(1'b1, burst_base(m) + k, '1, d));
      end
      for (int k = 0; k < Burst; k++) begin
        a_q[m].push_back(make_a(1'b0, burst_base(m) + k, '0, '0));
      end
    end
    wait_idle();
  endtask

  // Manager 1 holds rready low, manager 0 queues behind it
  task automatic test_back_pressure();
    int unsigned          hold;
    int unsigned          hits_before;
    logic [DataWidth-1:0] d;
    hold        = 6 + ($unsigned($random(seed)) % 16);
    hits_before = stall_hits;
    stall[1]    = 1'b1;
    for (int k = 0; k < 3; k++) begin
      d = $random(seed);
      a_q[1].push_back(make_a(1'b1, burst_base(1) + 8 + k, '1, d));
    end
    for (int k = 0; k < 3; k++) begin
      a_q[1].push_back(make_a(1'b0, burst_base(1) + 8 + k, '0, '0));
    end
    a_q[0].push_back(make_a(1'b0, burst_base(0), '0, '0));
    a_q[0].push_back(make_a(1'b0, burst_base(0) + 1, '0, '0));
    repeat (hold) @(posedge clk_i);
    if (stall_hits == hits_before) begin
      abort_run("Back-pressure test never saw a stalled response");
    end
    stall[1] = 1'b0;
    wait_idle();
  endtask

  // Word MemWords+5 aliases word 5 in the low index bits
  task automatic test_out_of_range();
    int unsigned          m;
    logic [DataWidth-1:0] d;
    m = NumMgr - 1;
    d = $random(seed);
    a_q[m].push_back(make_a(1'b1, 5, '1, d));
    d = $random(seed);
    a_q[m].push_back(make_a(1'b1, MemWords + 5, '1, d));
    a_q[m].push_back(make_a(1'b0, MemWords + 5, '0, '0));
    a_q[m].push_back(make_a(1'b0, 5, '0, '0));
    wait_idle();
  endtask

  task automatic test_outstanding_limit();
    int unsigned expect_out;
    stall = '1;
    for (int m = 0; m < NumMgr; m++) begin
      a_q[m].push_back(make_a(1'b0, burst_base(m), '0, '0));
      a_q[m].push_back(make_a(1'b0, burst_base(m) + 1, '0, '0));
    end
    // Buffers full, or every queued request granted
    expect_out = (MaxInFlight < 2 * NumMgr) ? MaxInFlight : 2 * NumMgr;
    repeat (SettleWait) @(posedge clk_i);
    check_gnt_count("outstanding under stall", gnt_cnt - done_cnt, expect_out, expect_out);
    stall = '0;
    wait_idle();
  endtask

  initial begin : run_tests
    rst_n_i = 1'b0;
    stall   = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    test_write_read();
    test_concurrent_bursts();
    test_back_pressure();
    test_out_of_range();
    test_outstanding_limit();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/obi_mem_sys.sv
// ####################
// OBI memory subsystem
// Manager ports through the mux into one shared SRAM
// ####################

`timescale 1ns/1ps
`default_nettype none

module obi_mem_sys #(
  parameter int unsigned NumMgr      = obi_sys_pkg::NumMgrDefault,
  parameter int unsigned MemWords    = obi_sys_pkg::MemWordsDefault,
  parameter int unsigned NumMaxTrans = obi_sys_pkg::NumMaxTransDefault,
  parameter int unsigned RspDepth    = obi_sys_pkg::RspDepthDefault
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  obi_pkg::obi_req_t [NumMgr-1:0] mgr_req_i,
  output obi_pkg::obi_rsp_t [NumMgr-1:0] mgr_rsp_o
);

  import obi_pkg::*;

  // Mux to memory link
  obi_req_t sram_req;
  obi_rsp_t sram_rsp;

  obi_mux #(
    .NumMgr      (NumMgr),
    .NumMaxTrans (NumMaxTrans)
  ) i_obi_mux (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .sbr_ports_req_i (mgr_req_i),
    .sbr_ports_rsp_o (mgr_rsp_o),
    .mgr_port_req_o  (sram_req),
    .mgr_port_rsp_i  (sram_rsp)
  );

  obi_sram #(
    .MemWords (MemWords),
    .RspDepth (RspDepth)
  ) i_obi_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (sram_req),
    .rsp_o   (sram_rsp)
  );

endmodule

`default_nettype wire

// File: hdl/obi_sram.sv
// ####################
// OBI SRAM subordinate
// Word memory with byte enables, range check, buffered responses
// ####################

`timescale 1ns/1ps
`default_nettype none

module obi_sram #(
  parameter int unsigned MemWords = 256,
  parameter int unsigned RspDepth = 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  obi_pkg::obi_req_t req_i,
  output obi_pkg::obi_rsp_t rsp_o
);

  import obi_pkg::*;

  // Byte offset bits below the word address
  localparam int unsigned OffWidth   = $clog2(BeWidth);
  localparam int unsigned WordWidth  = AddrWidth - OffWidth;
  localparam int unsigned MemIdxWidth = (MemWords > 1) ? $clog2(MemWords) : 1;
  localparam logic [WordWidth-1:0] MemLimit = WordWidth'(MemWords);

  logic [DataWidth-1:0]   mem_q [MemWords];
  logic [WordWidth-1:0]   word_addr;
  logic [MemIdxWidth-1:0] mem_idx;
  logic                   in_range;
  logic                   access;
  obi_r_chan_t            rsp_in;
  logic                   buf_full;
  logic                   buf_empty;

  assign word_addr = req_i.a.addr[AddrWidth-1:OffWidth];
  assign in_range  = (word_addr < MemLimit);
  assign mem_idx   = word_addr[MemIdxWidth-1:0];

  // Accept while the response buffer has a free slot
  assign rsp_o.gnt = !buf_full;
  assign access    = req_i.req && rsp_o.gnt;

  // Byte-wise merge, out of range leaves memory alone
  always_ff @(posedge clk_i) begin : proc_mem_write
    if (access && req_i.a.we && in_range) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (req_i.a.be[b]) begin
          mem_q[mem_idx][8*b +: 8] <= req_i.a.wdata[8*b +: 8];
        end
      end
    end
  end

  // Response for the current request
  always_comb begin : proc_rsp
    rsp_in.err   = !in_range;
    // Writes and errors answer with zero data
    rsp_in.rdata = (in_range && !req_i.a.we) ? mem_q[mem_idx] : '0;
  end

  obi_fifo #(
    .Depth   (RspDepth),
    .dtype_t (obi_r_chan_t)
  ) i_rsp_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (access),
    .data_i  (rsp_in),
    .pop_i   (rsp_o.rvalid && req_i.rready),
    .data_o  (rsp_o.r),
    .full_o  (buf_full),
    .empty_o (buf_empty)
  );

  // Buffered response, at least one cycle after the grant
  assign rsp_o.rvalid = !buf_empty;

  // Stalled response stays valid and unchanged
  a_r_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rsp_o.rvalid && !req_i.rready) |=> (rsp_o.rvalid && $stable(rsp_o.r)))
    else $error("R channel changed while stalled");

endmodule

`default_nettype wire

// File: hdl/obi_mux.sv
// ####################
// OBI multiplexer
// N managers onto one subordinate, responses routed back in order
// ####################

`timescale 1ns/1ps
`default_nettype none

module obi_mux #(
  parameter int unsigned NumMgr      = 2,
  parameter int unsigned NumMaxTrans = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  obi_pkg::obi_req_t [NumMgr-1:0] sbr_ports_req_i,
  output obi_pkg::obi_rsp_t [NumMgr-1:0] sbr_ports_rsp_o,
  output obi_pkg::obi_req_t              mgr_port_req_o,
  input  obi_pkg::obi_rsp_t              mgr_port_rsp_i
);

  import obi_pkg::*;

  if (NumMgr < 2) begin : gen_num_mgr_check
    $fatal(1, "obi_mux needs at least two manager ports");
  end

  localparam int unsigned IdxWidth = $clog2(NumMgr);
  typedef logic [IdxWidth-1:0] idx_t;

  logic        [NumMgr-1:0] sbr_req;
  logic        [NumMgr-1:0] sbr_gnt;
  obi_a_chan_t [NumMgr-1:0] sbr_a;

  obi_a_chan_t arb_a;
  logic        arb_req;
  idx_t        sel_idx;
  idx_t        rsp_idx;
  logic        fifo_full;
  logic        fifo_empty;
  logic        fifo_push;
  logic        fifo_pop;

  // Split the manager structs
  for (genvar i = 0; i < NumMgr; i++) begin : gen_sbr_req
    assign sbr_req[i] = sbr_ports_req_i[i].req;
    assign sbr_a[i]   = sbr_ports_req_i[i].a;
  end

  // Grant held back while the ID FIFO has no room
  obi_rr_arb #(
    .NumIn   (NumMgr),
    .dtype_t (obi_a_chan_t)
  ) i_obi_rr_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (sbr_req),
    .gnt_o   (sbr_gnt),
    .data_i  (sbr_a),
    .req_o   (arb_req),
    .gnt_i   (mgr_port_rsp_i.gnt && !fifo_full),
    .data_o  (arb_a),
    .idx_o   (sel_idx)
  );

  // Request path, combinational
  assign mgr_port_req_o.req    = arb_req && !fifo_full;
  assign mgr_port_req_o.a      = arb_a;
  // Only the manager owed the next response may accept it
  assign mgr_port_req_o.rready = sbr_ports_req_i[rsp_idx].rready;

  // Record source on grant, release on R handshake
  assign fifo_push = mgr_port_req_o.req && mgr_port_rsp_i.gnt;
  assign fifo_pop  = mgr_port_rsp_i.rvalid && mgr_port_req_o.rready;

  obi_fifo #(
    .Depth   (NumMaxTrans),
    .dtype_t (idx_t)
  ) i_id_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (fifo_push),
    .data_i  (sel_idx),
    .pop_i   (fifo_pop),
    .data_o  (rsp_idx),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // Response fan-out, others see rvalid low and r zero
  for (genvar i = 0; i < NumMgr; i++) begin : gen_sbr_rsp
    assign sbr_ports_rsp_o[i].gnt    = sbr_gnt[i];
    assign sbr_ports_rsp_o[i].rvalid = mgr_port_rsp_i.rvalid && (rsp_idx == idx_t'(i));
    assign sbr_ports_rsp_o[i].r      = (rsp_idx == idx_t'(i)) ? mgr_port_rsp_i.r : '0;
  end

  // Every response must match an earlier grant
  a_rsp_has_id : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mgr_port_rsp_i.rvalid |-> !fifo_empty)
    else $error("Response without recorded source");

endmodule

`default_nettype wire

// File: hdl/obi_rr_arb.sv
// ####################
// Round-robin arbiter
// Rotating priority with lock-in, forwards the winner's payload
// ####################

`timescale 1ns/1ps
`default_nettype none

module obi_rr_arb #(
  parameter int unsigned NumIn   = 2,
  parameter type         dtype_t = logic
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic   [NumIn-1:0]         req_i,
  output logic   [NumIn-1:0]         gnt_o,
  input  dtype_t [NumIn-1:0]         data_i,
  output logic                       req_o,
  input  logic                       gnt_i,
  output dtype_t                     data_o,
  output logic   [$clog2(NumIn)-1:0] idx_o
);

  localparam int unsigned IdxWidth = $clog2(NumIn);
  localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(NumIn - 1);

  // Priority pointer, first input to consider
  logic [IdxWidth-1:0] rr_q;
  // Held choice while a request waits for its grant
  logic                lock_q;
  logic [IdxWidth-1:0] lock_idx_q;

  logic [IdxWidth-1:0] sel_idx;
  logic                sel_found;
  logic                handshake;

  // Scan from the pointer upwards, wrapping around
  always_comb begin : proc_select
    int unsigned cand;
    sel_found = 1'b0;
    sel_idx   = rr_q;
    for (int unsigned i = 0; i < NumIn; i++) begin
      cand = (32'(rr_q) + i) % NumIn;
      if (!sel_found && req_i[cand]) begin
        sel_found = 1'b1;
        sel_idx   = IdxWidth'(cand);
      end
    end
  end

  // Locked choice wins over a fresh scan
  assign idx_o  = lock_q ? lock_idx_q : sel_idx;
  // Low when nobody requests, since the scan then lands on an idle input
  assign req_o  = req_i[idx_o];
  assign data_o = data_i[idx_o];

  assign handshake = req_o && gnt_i;

  // One-hot grant back to the winner
  always_comb begin : proc_gnt
    gnt_o = '0;
    gnt_o[idx_o] = handshake;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // Stalled request keeps its slot
      lock_q     <= req_o && !gnt_i;
      lock_idx_q <= idx_o;
      // Winner goes to the back of the line
      if (handshake) begin
        rr_q <= (idx_o == LastIdx) ? '0 : idx_o + 1'b1;
      end
    end
  end

  // Choice and its payload must not move under a pending request
  a_lock_in : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_o && !gnt_i) |=> (req_o && (idx_o == $past(idx_o)) && $stable(data_o)))
    else $error("Arbiter changed choice before grant");

endmodule

`default_nettype wire

// File: hdl/obi_fifo.sv
// ####################
// Synchronous FIFO
// Circular buffer of any payload type, no fall-through
// ####################

`timescale 1ns/1ps
`default_nettype none

module obi_fifo #(
  parameter int unsigned Depth   = 2,
  parameter type         dtype_t = logic
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   push_i,
  input  dtype_t data_i,
  input  logic   pop_i,
  output dtype_t data_o,
  output logic   full_o,
  output logic   empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);

  dtype_t              mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;

  // Occupancy flags from the count
  assign full_o  = (cnt_q == CntWidth'(Depth));
  assign empty_o = (cnt_q == '0);

  // Head entry, registered storage only
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap at the last slot
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o) else $error("FIFO push while full");

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o) else $error("FIFO pop while empty");

endmodule

`default_nettype wire

// File: hdl/obi_sys_pkg.sv
// ####################
// OBI subsystem sizing
// Default manager count, memory depth and buffer limits
// ####################

`default_nettype none

package obi_sys_pkg;

  // Managers sharing the memory
  localparam int unsigned NumMgrDefault      = 3;
  // SRAM depth in 32-bit words
  localparam int unsigned MemWordsDefault    = 256;
  // Outstanding transactions through the mux
  localparam int unsigned NumMaxTransDefault = 4;
  // Entries in the SRAM response buffer
  localparam int unsigned RspDepthDefault    = 2;

endpackage

`default_nettype wire

// File: hdl/obi_pkg.sv
// ####################
// OBI protocol package
// Bus widths and the A/R channel, request and response structs
// ####################

`default_nettype none

package obi_pkg;

  // Byte address and data widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  // One enable bit per data byte
  localparam int unsigned BeWidth   = DataWidth / 8;

  // A channel, manager to subordinate
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } obi_a_chan_t;

  // R channel, subordinate to manager
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } obi_r_chan_t;

  // Everything a manager drives
  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
    // Manager accepts a response
    logic        rready;
  } obi_req_t;

  // Everything a subordinate drives
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

endpackage

`default_nettype wire
